// File: user_data_path.f
hdl/user_data_path_pkg.sv
hdl/pkt_fifo.sv
hdl/input_arbiter.sv
hdl/output_port_lookup.sv
hdl/output_queues.sv
hdl/user_data_path.sv
verif/user_data_path_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the user data path and its testbench with Verilator, run, check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module user_data_path_tb -f user_data_path.f \
   -o udp_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/udp_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || grep -q "SIMULATION PASSED" sim.log

// File: verif/user_data_path_tb.sv
//--------------------------------------------------------------------------
// Testbench for the four-port user data path. Applies a table of packets,
// checks every output word against per-destination expected queues.
//--------------------------------------------------------------------------
`default_nettype none

module user_data_path_tb;
   import user_data_path_pkg::*;

   typedef struct packed {
      port_num_t   src;
      logic [47:0] mac;
      logic [4:0]  len;       // payload words after the header
      logic        throttle;
      logic        drain;     // wait for empty queues after this row
   } row_t;

   localparam logic [47:0] BCAST     = 48'hffff_ffff_ffff;
   localparam ctrl_t       LAST_CTRL = 8'h40;
   localparam int          NUM_ROWS  = 19;
   localparam row_t ROWS [NUM_ROWS] = '{
      '{2'd0, 48'h0002_1100_0001, 5'd2,  1'b0, 1'b1},
      '{2'd1, 48'h0002_1100_0002, 5'd5,  1'b0, 1'b1},
      '{2'd2, 48'h0002_1100_0003, 5'd15, 1'b0, 1'b1},
      '{2'd3, 48'h0002_1100_0004, 5'd3,  1'b0, 1'b1},
      '{2'd1, BCAST,              5'd4,  1'b0, 1'b1},
      '{2'd2, BCAST,              5'd2,  1'b0, 1'b1},
      // All four inputs at once
      '{2'd0, BCAST,              5'd15, 1'b0, 1'b0},
      '{2'd1, 48'h0002_1100_0011, 5'd15, 1'b0, 1'b0},
      '{2'd2, 48'h0002_1100_0012, 5'd15, 1'b0, 1'b0},
      '{2'd3, BCAST,              5'd15, 1'b0, 1'b0},
      '{2'd0, 48'h0002_1100_0014, 5'd3,  1'b0, 1'b1},
      // Random out_rdy, two maximal packets per input
      '{2'd0, 48'h0002_1100_0021, 5'd15, 1'b1, 1'b0},
      '{2'd1, BCAST,              5'd15, 1'b1, 1'b0},
      '{2'd2, 48'h0002_1100_0023, 5'd15, 1'b1, 1'b0},
      '{2'd3, 48'h0002_1100_0024, 5'd15, 1'b1, 1'b0},
      '{2'd0, BCAST,              5'd15, 1'b1, 1'b0},
      '{2'd1, 48'h0002_1100_0026, 5'd15, 1'b1, 1'b0},
      '{2'd2, BCAST,              5'd15, 1'b1, 1'b0},
      '{2'd3, 48'h0002_1100_0028, 5'd15, 1'b1, 1'b1}
   };

   logic       clk = 1'b0;
   logic       rst_n = 1'b0;
   pkt_word_t  in_word [NUM_PORTS] = '{default: '0};
   port_mask_t in_wr = '0;
   port_mask_t in_rdy;
   pkt_word_t  out_word [NUM_PORTS];
   port_mask_t out_wr;
   port_mask_t out_rdy = '1;

   // Stimulus queues per input, expected queues per destination and source
   pkt_word_t   tx_q  [NUM_PORTS][$];
   pkt_word_t   exp_q [NUM_PORTS*NUM_PORTS][$];
   port_mask_t  tx_busy = '0;
   port_mask_t  tx_gap = '0;
   port_mask_t  rx_busy = '0;
   port_num_t   rx_src [NUM_PORTS] = '{default: '0};
   logic        throttle_on = 1'b0;
   logic        saw_rdy_low = 1'b0;
   logic [31:0] lfsr = 32'h15cb;
   int          mismatches = 0;
   int          failures = 0;
   int          words_checked = 0;

   user_data_path user_data_path_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_word  (in_word),
      .in_wr    (in_wr),
      .in_rdy   (in_rdy),
      .out_word (out_word),
      .out_wr   (out_wr),
      .out_rdy  (out_rdy)
   );

   initial begin : clock_gen
      forever #10 clk = ~clk;
   end

   // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         r = {r[62:0], lfsr[0]};
      end
      return r;
   endfunction

   // Broadcast reaches every port but the source and unicast only the paired port
   function automatic port_mask_t expected_dst(input port_num_t src, input logic [47:0] mac);
      port_mask_t m;
      int         partner;
      partner = int'(src) ^ 1;
      for (int d = 0; d < NUM_PORTS; d++) begin
         if (mac == BCAST) begin
            m[d] = (d != int'(src));
         end else begin
            m[d] = (d == partner);
         end
      end
      return m;
   endfunction

   function automatic logic traffic_pending();
      for (int i = 0; i < NUM_PORTS; i++) begin
         if (tx_q[i].size() != 0) begin
            return 1'b1;
         end
      end
      for (int i = 0; i < NUM_PORTS * NUM_PORTS; i++) begin
         if (exp_q[i].size() != 0) begin
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   task automatic check_word(input string name, input pkt_word_t got, input pkt_word_t exp);
      words_checked++;
      if (got !== exp) begin
         mismatches++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_mask(input string name, input port_mask_t got, input port_mask_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(input string what);
      failures++;
      $display("error at %0t: %s", $time, what);
   endtask

   task automatic push_expected(input port_num_t src, input port_mask_t dst, input pkt_word_t w);
      for (int d = 0; d < NUM_PORTS; d++) begin
         if (dst[d]) begin
            exp_q[d * NUM_PORTS + int'(src)].push_back(w);
         end
      end
   endtask

   // Builds one packet for its input and the words each destination expects
   task automatic load_packet(input row_t row, input int idx);
      pkt_word_t  w;
      port_mask_t dst;
      dst = expected_dst(row.src, row.mac);
      w = '0;
      w.ctrl = HDR_CTRL;
      w.data[63:56] = 8'ha5;
      w.data[HDR_SRC_LSB +: $bits(port_num_t)] = row.src;
      w.data[15:8] = 8'(idx);
      w.data[7:0] = 8'(row.len) + 8'd1;
      tx_q[row.src].push_back(w);
      w.data[HDR_DST_LSB +: NUM_PORTS] = dst;
      push_expected(row.src, dst, w);
      for (int i = 0; i < int'(row.len); i++) begin
         w.ctrl = (i == int'(row.len) - 1) ? LAST_CTRL : '0;
         w.data = (i == 0) ? {row.mac, 16'(rand_bits(16))} : rand_bits(64);
         tx_q[row.src].push_back(w);
         push_expected(row.src, dst, w);
      end
   endtask

   //-----------------------------------------------------------------------
   // Input drivers with one word per port per cycle
   //-----------------------------------------------------------------------
   initial begin : drive_inputs
      port_mask_t wr_next;
      forever begin
         @(posedge clk);
         wr_next = '0;
         if (rst_n && throttle_on && in_rdy != '1) begin
            saw_rdy_low = 1'b1;
         end
         for (int p = 0; p < NUM_PORTS; p++) begin
            // Idle cycle after a packet so in_rdy counts its last word
            if (tx_gap[p]) begin
               tx_gap[p] = 1'b0;
            end else if (tx_q[p].size() != 0 && (tx_busy[p] || in_rdy[p])) begin
               in_word[p] <= tx_q[p][0];
               wr_next[p] = 1'b1;
               tx_busy[p] = (tx_q[p][0].ctrl == '0) || (tx_q[p][0].ctrl == HDR_CTRL);
               tx_gap[p] = !tx_busy[p];
               void'(tx_q[p].pop_front());
            end
         end
         in_wr <= wr_next;
      end
   end

   initial begin : drive_out_rdy
      forever begin
         @(posedge clk);
         if (throttle_on) begin
            out_rdy <= port_mask_t'(rand_bits(NUM_PORTS));
         end else begin
            out_rdy <= '1;
         end
      end
   end

   //-----------------------------------------------------------------------
   // Output checker
   //-----------------------------------------------------------------------
   initial begin : check_outputs
      int q;
      forever begin
         @(posedge clk);
         for (int p = 0; p < NUM_PORTS; p++) begin
            if (rst_n && out_wr[p]) begin
               if (out_word[p].ctrl == HDR_CTRL) begin
                  if (rx_busy[p]) begin
                     report_failure($sformatf("port %0d started a packet inside another", p));
                  end
                  rx_src[p] = out_word[p].data[HDR_SRC_LSB +: $bits(port_num_t)];
                  rx_busy[p] = 1'b1;
               end
               q = p * NUM_PORTS + int'(rx_src[p]);
               if (!rx_busy[p]) begin
                  report_failure($sformatf("port %0d sent a word outside any packet", p));
               end else if (exp_q[q].size() == 0) begin
                  report_failure($sformatf("port %0d sent an unexpected word from port %0d",
                                           p, rx_src[p]));
               end else begin
                  check_word($sformatf("out_word[%0d]", p), out_word[p], exp_q[q].pop_front());
               end
               if (out_word[p].ctrl != '0 && out_word[p].ctrl != HDR_CTRL) begin
                  rx_busy[p] = 1'b0;
               end
            end
         end
      end
   end

   initial begin : watchdog
      int limit;
      limit = 2000;
      for (int r = 0; r < NUM_ROWS; r++) begin
         limit += 40 * (int'(ROWS[r].len) + 1);
      end
      repeat (limit) @(posedge clk);
      $display("timeout: traffic did not drain within %0d cycles", limit);
      $display("SIMULATION FAILED");
      $finish;
   end

   initial begin : main
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      check_mask("out_wr", out_wr, '0);
      check_mask("in_rdy", in_rdy, '1);
      for (int r = 0; r < NUM_ROWS; r++) begin
         throttle_on <= ROWS[r].throttle;
         load_packet(ROWS[r], r);
         if (ROWS[r].drain) begin
            while (traffic_pending()) begin
               @(posedge clk);
            end
         end
      end
      throttle_on <= 1'b0;
      repeat (40) @(posedge clk);
      // Everything drained, so the data path is back to its reset levels
      check_mask("out_wr", out_wr, '0);
      check_mask("in_rdy", in_rdy, '1);
      if (!saw_rdy_low) begin
         report_failure("in_rdy never dropped under back-pressure");
      end
      $display("%0d words checked, %0d mismatches, %0d other errors",
               words_checked, mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: hdl/user_data_path.sv
//--------------------------------------------------------------------------
// Four-port user data path. Input arbiter, output port lookup and output
// queues in a single pipeline; sender and receiver use wr strobes and
// packet-level rdy.
//--------------------------------------------------------------------------
`default_nettype none

module user_data_path (
   input  logic                           clk,
   input  logic                           rst_n,
   input  user_data_path_pkg::pkt_word_t  in_word [user_data_path_pkg::NUM_PORTS],
   input  user_data_path_pkg::port_mask_t in_wr,
   output user_data_path_pkg::port_mask_t in_rdy,
   output user_data_path_pkg::pkt_word_t  out_word [user_data_path_pkg::NUM_PORTS],
   output user_data_path_pkg::port_mask_t out_wr,
   input  user_data_path_pkg::port_mask_t out_rdy
);
   import user_data_path_pkg::*;

   // Arbiter to lookup
   pkt_word_t arb_word;
   logic      arb_wr;

   // Lookup to queues
   pkt_word_t lut_word;
   logic      lut_wr;

   // Queue room back to the arbiter
   logic      q_rdy;

   input_arbiter input_arbiter_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_word  (in_word),
      .in_wr    (in_wr),
      .in_rdy   (in_rdy),
      .arb_word (arb_word),
      .arb_wr   (arb_wr),
      .q_rdy    (q_rdy)
   );

   output_port_lookup output_port_lookup_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .arb_word (arb_word),
      .arb_wr   (arb_wr),
      .lut_word (lut_word),
      .lut_wr   (lut_wr)
   );

   output_queues output_queues_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .lut_word (lut_word),
      .lut_wr   (lut_wr),
      .q_rdy    (q_rdy),
      .out_word (out_word),
      .out_wr   (out_wr),
      .out_rdy  (out_rdy)
   );

endmodule

`default_nettype wire

// File: hdl/output_queues.sv
//--------------------------------------------------------------------------
// Output queues. Copies each packet into the FIFO of every port in its
// header mask and drains each FIFO to its port a whole packet at a time.
//--------------------------------------------------------------------------
`default_nettype none

module output_queues (
   input  logic                           clk,
   input  logic                           rst_n,
   input  user_data_path_pkg::pkt_word_t  lut_word,
   input  logic                           lut_wr,
   output logic                           q_rdy,
   output user_data_path_pkg::pkt_word_t  out_word [user_data_path_pkg::NUM_PORTS],
   output user_data_path_pkg::port_mask_t out_wr,
   input  user_data_path_pkg::port_mask_t out_rdy
);
   import user_data_path_pkg::*;

   logic       hdr;
   port_mask_t hdr_mask;
   port_mask_t dst_mask;
   port_mask_t fifo_wr;
   port_mask_t fifo_rd;
   port_mask_t fifo_empty;
   port_mask_t fifo_room;
   port_mask_t busy;

   //-----------------------------------------------------------------------
   // Enqueue side
   //-----------------------------------------------------------------------
   assign hdr      = (lut_word.ctrl == HDR_CTRL);
   assign hdr_mask = lut_word.data[HDR_DST_LSB +: NUM_PORTS];
   // Header word uses its own mask, the rest use the latched one
   assign fifo_wr  = lut_wr ? (hdr ? hdr_mask : dst_mask) : '0;
   assign q_rdy    = &fifo_room;

   always_ff @(posedge clk) begin
      if (lut_wr && hdr) begin
         dst_mask <= hdr_mask;
      end
   end

   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_out_fifo
      pkt_fifo out_fifo (
         .clk     (clk),
         .rst_n   (rst_n),
         .wr      (fifo_wr[i]),
         .wr_word (lut_word),
         .rd      (fifo_rd[i]),
         .rd_word (out_word[i]),
         .empty   (fifo_empty[i]),
         .room    (fifo_room[i])
      );
      // out_rdy only matters at a packet boundary
      assign fifo_rd[i] = !fifo_empty[i] && (busy[i] || out_rdy[i]);
   end

   //-----------------------------------------------------------------------
   // Dequeue side
   //-----------------------------------------------------------------------
   assign out_wr = fifo_rd;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy <= '0;
      end else begin
         for (int p = 0; p < NUM_PORTS; p++) begin
            if (fifo_rd[p]) begin
               busy[p] <= !is_last(out_word[p].ctrl);
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/output_port_lookup.sv
//--------------------------------------------------------------------------
// Output port lookup. Delays the stream by one word so that the module
// header can carry a destination mask taken from the MAC that follows it.
//--------------------------------------------------------------------------
`default_nettype none

module output_port_lookup (
   input  logic                          clk,
   input  logic                          rst_n,
   input  user_data_path_pkg::pkt_word_t arb_word,
   input  logic                          arb_wr,
   output user_data_path_pkg::pkt_word_t lut_word,
   output logic                          lut_wr
);
   import user_data_path_pkg::*;

   pkt_word_t  hold_word;
   logic       hold_valid;
   logic       hold_hdr;
   port_num_t  src_port;
   mac_addr_t  dst_mac;
   port_mask_t src_mask;
   port_mask_t dst_mask;

   //-----------------------------------------------------------------------
   // Destination decision
   //-----------------------------------------------------------------------
   assign src_port = hold_word.data[HDR_SRC_LSB +: $bits(port_num_t)];
   assign dst_mac  = arb_word.data[MAC_LSB +: MAC_WIDTH];
   assign src_mask = port_mask_t'(1) << src_port;

   always_comb begin
      if (dst_mac == '1) begin
         // Broadcast floods everything but the source
         dst_mask = ~src_mask;
      end else begin
         // NIC pairing of 0 with 1 and 2 with 3
         dst_mask = port_mask_t'(1) << (src_port ^ port_num_t'(1));
      end
   end

   //-----------------------------------------------------------------------
   // One-word hold stage
   //-----------------------------------------------------------------------
   // A held word leaves when the next one arrives, a closing word at once
   assign lut_wr = hold_valid && (arb_wr || is_last(hold_word.ctrl));

   always_comb begin
      lut_word = hold_word;
      if (hold_hdr) begin
         lut_word.data[HDR_DST_LSB +: NUM_PORTS] = dst_mask;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hold_valid <= 1'b0;
      end else if (arb_wr) begin
         hold_valid <= 1'b1;
      end else if (lut_wr) begin
         hold_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (arb_wr) begin
         hold_word <= arb_word;
         hold_hdr  <= (arb_word.ctrl == HDR_CTRL);
      end
   end

endmodule

`default_nettype wire

// File: hdl/input_arbiter.sv
//--------------------------------------------------------------------------
// Input FIFOs for the four ports and a round-robin arbiter that hands the
// shared pipeline to one input for one whole packet at a time.
//--------------------------------------------------------------------------
`default_nettype none

module input_arbiter (
   input  logic                           clk,
   input  logic                           rst_n,
   input  user_data_path_pkg::pkt_word_t  in_word [user_data_path_pkg::NUM_PORTS],
   input  user_data_path_pkg::port_mask_t in_wr,
   output user_data_path_pkg::port_mask_t in_rdy,
   output user_data_path_pkg::pkt_word_t  arb_word,
   output logic                           arb_wr,
   input  logic                           q_rdy
);
   import user_data_path_pkg::*;

   typedef enum logic {ARB_IDLE, ARB_SEND} arb_state_t;

   arb_state_t state;
   port_num_t  grant;
   port_num_t  next_port;
   logic       found;
   logic [1:0] settle;
   logic       pop;
   port_mask_t fifo_empty;
   port_mask_t fifo_rd;
   pkt_word_t  head_word [NUM_PORTS];
   pkt_word_t  sel_word;

   //-----------------------------------------------------------------------
   // Input FIFOs
   //-----------------------------------------------------------------------
   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in_fifo
      pkt_fifo in_fifo (
         .clk     (clk),
         .rst_n   (rst_n),
         .wr      (in_wr[i]),
         .wr_word (in_word[i]),
         .rd      (fifo_rd[i]),
         .rd_word (head_word[i]),
         .empty   (fifo_empty[i]),
         .room    (in_rdy[i])
      );
      assign fifo_rd[i] = pop && (grant == port_num_t'(i));
   end

   assign sel_word = head_word[grant];
   assign pop      = (state == ARB_SEND) && !fifo_empty[grant];

   // Next non-empty input after the last one granted
   always_comb begin
      port_num_t cand;
      next_port = grant;
      found     = 1'b0;
      for (int i = 1; i <= NUM_PORTS; i++) begin
         cand = grant + port_num_t'(i);
         if (!found && !fifo_empty[cand]) begin
            next_port = cand;
            found     = 1'b1;
         end
      end
   end

   //-----------------------------------------------------------------------
   // Grant FSM
   //-----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state  <= ARB_IDLE;
         grant  <= port_num_t'(NUM_PORTS - 1);
         settle <= '0;
         arb_wr <= 1'b0;
      end else begin
         arb_wr <= pop;
         case (state)
            ARB_IDLE: begin
               // Let the last packet land before trusting q_rdy
               if (settle != '0) begin
                  settle <= settle - 1'b1;
               end else if (q_rdy && found) begin
                  grant <= next_port;
                  state <= ARB_SEND;
               end
            end
            ARB_SEND: begin
               if (pop && is_last(sel_word.ctrl)) begin
                  state  <= ARB_IDLE;
                  settle <= 2'(PIPE_SETTLE);
               end
            end
            default: state <= ARB_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         arb_word <= sel_word;
      end
   end

endmodule

`default_nettype wire

// File: hdl/pkt_fifo.sv
//--------------------------------------------------------------------------
// Word FIFO for packet words. The head word is shown on rd_word, and room
// tells a sender that a whole maximal packet still fits.
//--------------------------------------------------------------------------
`default_nettype none

module pkt_fifo (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          wr,
   input  user_data_path_pkg::pkt_word_t wr_word,
   input  logic                          rd,
   output user_data_path_pkg::pkt_word_t rd_word,
   output logic                          empty,
   output logic                          room
);
   import user_data_path_pkg::*;

   pkt_word_t   mem [FIFO_DEPTH];
   fifo_addr_t  wr_ptr;
   fifo_addr_t  rd_ptr;
   fifo_count_t count;

   // Storage
   always_ff @(posedge clk) begin
      if (wr) begin
         mem[wr_ptr] <= wr_word;
      end
   end

   // Pointers and fill level
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr, rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign rd_word = mem[rd_ptr];
   assign empty   = (count == '0);
   assign room    = (count <= FIFO_ROOM_MAX);

endmodule

`default_nettype wire

// File: hdl/user_data_path_pkg.sv
//--------------------------------------------------------------------------
// Shared widths, word types, module header layout and FIFO sizing for the
// four-port user data path. Every block imports this package.
//--------------------------------------------------------------------------
`default_nettype none

package user_data_path_pkg;

   localparam int NUM_PORTS       = 4;
   localparam int DATA_WIDTH      = 64;
   localparam int CTRL_WIDTH      = 8;

   // Module header layout, destination mask in the top 16 bits
   localparam int HDR_SRC_LSB     = 16;
   localparam int HDR_DST_LSB     = 48;

   // Ethernet destination MAC sits in the top of the first payload word
   localparam int MAC_WIDTH       = 48;
   localparam int MAC_LSB         = DATA_WIDTH - MAC_WIDTH;

   localparam int FIFO_DEPTH      = 32;
   localparam int MAX_PKT_WORDS   = 16;
   localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);

   // Cycles for a closing word to reach the output FIFO counts
   localparam int PIPE_SETTLE     = 2;

   typedef logic [DATA_WIDTH-1:0]        data_t;
   typedef logic [CTRL_WIDTH-1:0]        ctrl_t;
   typedef logic [$clog2(NUM_PORTS)-1:0] port_num_t;
   typedef logic [NUM_PORTS-1:0]         port_mask_t;
   typedef logic [FIFO_ADDR_WIDTH-1:0]   fifo_addr_t;
   typedef logic [FIFO_ADDR_WIDTH:0]     fifo_count_t;
   typedef logic [MAC_WIDTH-1:0]         mac_addr_t;

   typedef struct packed {
      ctrl_t ctrl;
      data_t data;
   } pkt_word_t;

   localparam ctrl_t HDR_CTRL = '1;

   // Highest fill level that still leaves room for a maximal packet
   localparam fifo_count_t FIFO_ROOM_MAX = fifo_count_t'(FIFO_DEPTH - MAX_PKT_WORDS);

   // Closing word: nonzero control that is not the module header
   function automatic logic is_last(ctrl_t ctrl);
      return (ctrl != '0) && (ctrl != HDR_CTRL);
   endfunction

endpackage

`default_nettype wire
